/* mips_fetch.f */
src/mips_fetch_pkg.sv
src/cycle_fsm.sv
src/cycle_timer.sv
src/pc_register.sv
src/instr_decode.sv
src/branch_target.sv
src/mips_fetch.sv
verification/mips_fetch_tb.sv

/* Makefile */
SOURCES := $(wildcard src/*.sv) $(wildcard verification/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vmips_fetch_tb: mips_fetch.f $(SOURCES)
	verilator --binary --timing --top-module mips_fetch_tb -f mips_fetch.f -o Vmips_fetch_tb

run: obj_dir/Vmips_fetch_tb
	./obj_dir/Vmips_fetch_tb | tee sim.log
	grep -q "^PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

/* verification/mips_fetch_tb.sv */
module mips_fetch_tb;

    import mips_fetch_pkg::*;

    localparam int nrows     = 19;
    localparam int cycle_cap = nrows * 12 + 50; // worst row is 11 cycles

    typedef struct packed {
        logic [31:0] addr;  // expected fetch address
        logic [31:0] word;
        logic [31:0] rs;
        logic [31:0] rt;
        int          len;   // execute cycles of the class
        logic        stall;
    } row_t;

    logic        clk;
    logic        reset;
    logic        waitrequest;
    logic [31:0] readdata;
    logic [31:0] rs_value;
    logic [31:0] rt_value;
    fetch_req_t  fetch;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        instr_done;

    row_t        prog [0:nrows-1];
    int          value_errors;
    int          other_errors;
    int          done_count;
    int          cycles;
    bit          timed_out;
    string       where;
    int          stall_left;
    int          exec_stalls;
    int          exec_count;
    int          fetch_cycle;
    bit          accepted;
    bit          retired;
    logic [31:0] last_word;

    mips_fetch i_mips_fetch (
        .clk         (clk),
        .reset       (reset),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .rs_value    (rs_value),
        .rt_value    (rt_value),
        .fetch       (fetch),
        .instr       (instr),
        .pc          (pc),
        .instr_done  (instr_done)
    );

    function automatic logic [31:0] r_type(input logic [5:0] funct,
                                           input logic [4:0] rs, input logic [4:0] rt);
        return {6'h00, rs, rt, 5'd3, 5'd0, funct};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_type(input logic [5:0] op, input logic [25:0] index);
        return {op, index};
    endfunction

    task automatic set_row(input int idx, input logic [31:0] addr, input logic [31:0] word,
                           input logic [31:0] rs, input logic [31:0] rt, input int len,
                           input logic stall);
        prog[idx] = '{addr: addr, word: word, rs: rs, rt: rt, len: len, stall: stall};
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        value_errors++;
        $display("error: %s at %s: got %h, expected %h", name, where, got, expected);
    endtask

    task automatic close_run();
        $display("%0d value errors, %0d other errors, %0d of %0d instructions retired%s",
                 value_errors, other_errors, done_count, nrows,
                 timed_out ? ", timed out" : "");
        if (value_errors == 0 && other_errors == 0 && !timed_out) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycles    = 0;
        timed_out = 1'b0;
        while (cycles < cycle_cap) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run still going after %0d cycles", cycle_cap);
        timed_out = 1'b1;
        close_run();
    end

    initial begin
        void'($urandom(32'h95c8f710));
        reset        = 1'b1;
        waitrequest  = 1'b0;
        readdata     = 32'h0;
        rs_value     = 32'h0;
        rt_value     = 32'h0;
        value_errors = 0;
        other_errors = 0;
        done_count   = 0;
        last_word    = 32'h0; // ir clears on reset
        where        = "reset";

        set_row(0,  32'hbfc00000, r_type(6'h21, 5'd1, 5'd2), 32'h0, 32'h0, 2, 1'b0); // addu
        set_row(1,  32'hbfc00004, i_type(6'h23, 5'd4, 5'd5, 16'h0010), 32'h0, 32'h0, 3, 1'b1);
        set_row(2,  32'hbfc00008, r_type(6'h18, 5'd1, 5'd2), 32'h0, 32'h0, 4, 1'b0); // mult
        set_row(3,  32'hbfc0000c, i_type(6'h2b, 5'd4, 5'd5, 16'h0014), 32'h0, 32'h0, 3, 1'b0);
        // taken beq to bfc00014 + 4*4
        set_row(4,  32'hbfc00010, i_type(6'h04, 5'd1, 5'd2, 16'h0004), 32'h55, 32'h55, 2, 1'b0);
        set_row(5,  32'hbfc00014, r_type(6'h25, 5'd1, 5'd2), 32'h0, 32'h0, 2, 1'b1); // or in slot
        set_row(6,  32'hbfc00024, i_type(6'h05, 5'd1, 5'd2, 16'h0008), 32'h7, 32'h7, 2, 1'b0);
        set_row(7,  32'hbfc00028, r_type(6'h1b, 5'd1, 5'd2), 32'h0, 32'h0, 4, 1'b1); // divu
        set_row(8,  32'hbfc0002c, i_type(6'h04, 5'd1, 5'd2, 16'h0040), 32'h1, 32'h2, 2, 1'b0);
        // j keeps region b of bfc00034 with index 0100040 << 2
        set_row(9,  32'hbfc00030, j_type(6'h02, 26'h0100040), 32'h0, 32'h0, 2, 1'b0);
        set_row(10, 32'hbfc00034, 32'h00000000, 32'h0, 32'h0, 2, 1'b1); // nop in slot
        set_row(11, 32'hb0400100, j_type(6'h03, 26'h0100080), 32'h0, 32'h0, 2, 1'b0); // jal
        set_row(12, 32'hb0400104, r_type(6'h19, 5'd1, 5'd2), 32'h0, 32'h0, 4, 1'b0); // multu
        // taken bne backward to b0400204 - 16*4
        set_row(13, 32'hb0400200, i_type(6'h05, 5'd1, 5'd2, 16'hfff0), 32'h1, 32'h2, 2, 1'b1);
        set_row(14, 32'hb0400204, i_type(6'h2b, 5'd4, 5'd5, 16'h0000), 32'h0, 32'h0, 3, 1'b0);
        set_row(15, 32'hb04001c4, r_type(6'h08, 5'd31, 5'd0), 32'h80001000, 32'h0, 2, 1'b1);
        set_row(16, 32'hb04001c8, r_type(6'h1a, 5'd1, 5'd2), 32'h0, 32'h0, 4, 1'b0); // div
        set_row(17, 32'h80001000, r_type(6'h21, 5'd1, 5'd2), 32'h0, 32'h0, 2, 1'b0);
        set_row(18, 32'h80001004, i_type(6'h23, 5'd4, 5'd5, 16'h0020), 32'h0, 32'h0, 3, 1'b0);

        repeat (4) begin
            @(negedge clk);
            if (fetch.read !== 1'b0) report_mismatch("fetch.read", 32'(fetch.read), 32'h0);
            if (instr_done !== 1'b0) report_mismatch("instr_done", 32'(instr_done), 32'h0);
        end
        reset = 1'b0;

        for (int i = 0; i < nrows; i++) begin
            where       = $sformatf("row %0d", i);
            accepted    = 1'b0;
            stall_left  = prog[i].stall ? $urandom_range(3, 0) : 0;
            fetch_cycle = cycles + 1; // first fetch cycle follows the next edge
            while (!accepted) begin
                @(negedge clk);
                readdata    = prog[i].word;
                rs_value    = prog[i].rs;
                rt_value    = prog[i].rt;
                waitrequest = (stall_left != 0);
                #1;
                if (instr_done) begin
                    done_count++;
                    other_errors++;
                    $display("instr_done pulsed while fetching %s", where);
                end
                if (instr !== last_word) report_mismatch("instr", instr, last_word);
                if (fetch.read) begin
                    if (fetch.address !== prog[i].addr) begin
                        report_mismatch("fetch.address", fetch.address, prog[i].addr);
                    end
                    if (pc !== prog[i].addr) report_mismatch("pc", pc, prog[i].addr);
                    if (waitrequest) begin
                        stall_left--;
                    end else begin
                        accepted = 1'b1; // accept on the coming edge
                    end
                end
            end

            last_word   = prog[i].word;
            exec_stalls = prog[i].stall ? $urandom_range(3, 0) : 0;
            exec_count  = 0;
            retired     = 1'b0;
            while (!retired) begin
                @(negedge clk);
                readdata    = ~prog[i].word; // must not reach the ir
                waitrequest = (exec_stalls != 0) && ($urandom_range(1, 0) == 1);
                #1;
                if (fetch.read !== 1'b0) report_mismatch("fetch.read", 32'(fetch.read), 32'h0);
                if (instr !== prog[i].word) report_mismatch("instr", instr, prog[i].word);
                if (pc !== prog[i].addr) report_mismatch("pc", pc, prog[i].addr);
                if (fetch.address !== prog[i].addr) begin
                    report_mismatch("fetch.address", fetch.address, prog[i].addr);
                end
                if (waitrequest) begin
                    exec_stalls--;
                    if (instr_done) begin
                        other_errors++;
                        $display("instr_done pulsed during a stall at %s", where);
                    end
                end else begin
                    exec_count++;
                    if (instr_done) begin
                        retired = 1'b1;
                        done_count++;
                        if (exec_count != prog[i].len) begin
                            report_mismatch("execute cycles", exec_count, prog[i].len);
                        end
                        if (!prog[i].stall && (cycles - fetch_cycle + 1 != prog[i].len + 1)) begin
                            report_mismatch("instruction cycles", cycles - fetch_cycle + 1,
                                            prog[i].len + 1);
                        end
                    end else if (exec_count >= prog[i].len) begin
                        retired = 1'b1; // give up on this row
                        other_errors++;
                        $display("no instr_done after %0d execute cycles at %s",
                                 exec_count, where);
                    end
                end
            end
        end

        // pc after the last retire is 80001004 + 4
        where = "end of program";
        @(negedge clk);
        waitrequest = 1'b0;
        readdata    = 32'h0;
        #1;
        if (pc !== 32'h80001008) report_mismatch("pc", pc, 32'h80001008);
        if (done_count != nrows) report_mismatch("instr_done count", done_count, nrows);
        close_run();
    end

endmodule

/* src/mips_fetch.sv */
module mips_fetch (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       waitrequest,
    input  logic [31:0]                readdata,
    input  logic [31:0]                rs_value,
    input  logic [31:0]                rt_value,
    output mips_fetch_pkg::fetch_req_t fetch,
    output logic [31:0]                instr,
    output logic [31:0]                pc,
    output logic                       instr_done
);

    import mips_fetch_pkg::*;

    logic         ir_load;
    logic         timer_start;
    logic         retire;
    logic         read;
    logic         last_exec;
    instr_class_t iclass;
    xfer_kind_t   kind;
    logic [15:0]  imm;
    logic [25:0]  index;
    pc_update_t   upd;

    cycle_fsm i_cycle_fsm (
        .clk         (clk),
        .reset       (reset),
        .waitrequest (waitrequest),
        .last_exec   (last_exec),
        .ir_load     (ir_load),
        .timer_start (timer_start),
        .retire      (retire),
        .read        (read)
    );

    cycle_timer i_cycle_timer (
        .clk         (clk),
        .reset       (reset),
        .waitrequest (waitrequest),
        .timer_start (timer_start),
        .iclass      (iclass),
        .last_exec   (last_exec)
    );

    instr_decode i_instr_decode (
        .clk         (clk),
        .reset       (reset),
        .waitrequest (waitrequest),
        .ir_load     (ir_load),
        .readdata    (readdata),
        .instr       (instr),
        .iclass      (iclass),
        .kind        (kind),
        .imm         (imm),
        .index       (index)
    );

    branch_target i_branch_target (
        .pc       (pc),
        .kind     (kind),
        .imm      (imm),
        .index    (index),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .retire   (retire),
        .upd      (upd)
    );

    pc_register i_pc_register (
        .clk         (clk),
        .reset       (reset),
        .waitrequest (waitrequest),
        .upd         (upd),
        .pc          (pc)
    );

    assign fetch.read    = read;
    assign fetch.address = pc; // fetch always from current pc
    assign instr_done    = retire;

endmodule

/* src/branch_target.sv */
module branch_target (
    input  logic [31:0]                pc,
    input  mips_fetch_pkg::xfer_kind_t kind,
    input  logic [15:0]                imm,
    input  logic [25:0]                index,
    input  logic [31:0]                rs_value,
    input  logic [31:0]                rt_value,
    input  logic                       retire,
    output mips_fetch_pkg::pc_update_t upd
);

    import mips_fetch_pkg::*;

    logic [31:0] seq_pc;
    logic [31:0] branch_pc;
    logic [31:0] jump_pc;
    logic [31:0] target;
    logic        taken;
    logic        regs_equal;

    assign seq_pc     = pc + 32'd4;
    assign branch_pc  = seq_pc + {{14{imm[15]}}, imm, 2'b00}; // word offset
    assign jump_pc    = {seq_pc[31:28], index, 2'b00};        // same 256 MB region
    assign regs_equal = (rs_value == rt_value);

    always_comb begin
        target = seq_pc;
        taken  = 1'b0;
        case (kind)
            xfer_beq: begin
                target = branch_pc;
                taken  = regs_equal;
            end
            xfer_bne: begin
                target = branch_pc;
                taken  = !regs_equal;
            end
            xfer_j: begin
                target = jump_pc;
                taken  = 1'b1;
            end
            xfer_jr: begin
                target = rs_value;
                taken  = 1'b1;
            end
            default: begin
                target = seq_pc;
                taken  = 1'b0;
            end
        endcase
    end

    assign upd.advance = retire;
    assign upd.taken   = taken;
    assign upd.seq_pc  = seq_pc;
    assign upd.target  = target;

endmodule

/* src/instr_decode.sv */
module instr_decode (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         waitrequest,
    input  logic                         ir_load,
    input  logic [31:0]                  readdata,
    output logic [31:0]                  instr,
    output mips_fetch_pkg::instr_class_t iclass,
    output mips_fetch_pkg::xfer_kind_t   kind,
    output logic [15:0]                  imm,
    output logic [25:0]                  index
);

    import mips_fetch_pkg::*;

    logic [31:0] ir;
    logic [5:0]  opcode;
    logic [5:0]  funct;

    function automatic instr_class_t classify(input logic [31:0] word);
        instr_class_t c;
        c = class_alu;
        if (word[31:26] == op_lw || word[31:26] == op_sw) begin
            c = class_mem;
        end else if (word[31:26] == op_special) begin
            case (word[5:0])
                funct_mult, funct_multu, funct_div, funct_divu: c = class_long;
                default:                                        c = class_alu;
            endcase
        end
        return c;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            ir <= 32'd0; // decodes as a plain alu op
        end else if (ir_load && !waitrequest) begin
            ir <= readdata;
        end
    end

    assign opcode = ir[31:26];
    assign funct  = ir[5:0];

    always_comb begin
        case (opcode)
            op_j, op_jal: kind = xfer_j;
            op_beq:       kind = xfer_beq;
            op_bne:       kind = xfer_bne;
            op_special:   kind = (funct == funct_jr) ? xfer_jr : xfer_none;
            default:      kind = xfer_none;
        endcase
    end

    // timer loads on the accept edge, before ir holds the new word
    assign iclass = ir_load ? classify(readdata) : classify(ir);

    assign instr = ir;
    assign imm   = ir[15:0];
    assign index = ir[25:0];

endmodule

/* src/pc_register.sv */
module pc_register (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       waitrequest,
    input  mips_fetch_pkg::pc_update_t upd,
    output logic [31:0]                pc
);

    import mips_fetch_pkg::*;

    logic [31:0] pc_q;
    logic [31:0] deferred; // target waiting for the delay slot
    logic        pending;

    logic        step;

    assign step = upd.advance && !waitrequest;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q    <= reset_vector;
            pending <= 1'b0;
        end else if (step) begin
            if (pending) begin
                pc_q    <= deferred; // delay slot just retired
                pending <= 1'b0;
            end else begin
                pc_q <= upd.seq_pc;
            end
            // a transfer only arms the redirect; the slot runs first
            if (upd.taken) begin
                pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step && upd.taken) begin
            deferred <= upd.target;
        end
    end

    assign pc = pc_q;

endmodule

/* src/cycle_timer.sv */
module cycle_timer (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         waitrequest,
    input  logic                         timer_start,
    input  mips_fetch_pkg::instr_class_t iclass,
    output logic                         last_exec
);

    import mips_fetch_pkg::*;

    logic [2:0] remaining;
    logic [2:0] load_len;

    always_comb begin
        case (iclass)
            class_mem:  load_len = exec_len_mem;
            class_long: load_len = exec_len_long;
            default:    load_len = exec_len_alu;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            remaining <= 3'd0;
        end else if (!waitrequest) begin
            if (timer_start) begin
                remaining <= load_len; // class of the word being fetched
            end else if (remaining != 3'd0) begin
                remaining <= remaining - 3'd1;
            end
        end
    end

    assign last_exec = (remaining == 3'd1);

endmodule

/* src/cycle_fsm.sv */
module cycle_fsm (
    input  logic clk,
    input  logic reset,
    input  logic waitrequest,
    input  logic last_exec,
    output logic ir_load,
    output logic timer_start,
    output logic retire,
    output logic read
);

    import mips_fetch_pkg::*;

    cycle_state_t state;
    cycle_state_t state_next;
    logic         accept; // fetch completes this edge
    logic         finish; // last execute cycle, not stalled

    assign accept = (state == st_fetch) && !waitrequest;
    assign finish = (state == st_exec) && last_exec && !waitrequest;

    always_comb begin
        state_next = state;
        case (state)
            st_reset: begin
                state_next = st_fetch; // first fetch right after reset
            end
            st_fetch: begin
                if (accept) begin
                    state_next = st_exec;
                end
            end
            st_exec: begin
                if (finish) begin
                    state_next = st_fetch;
                end
            end
            default: begin
                state_next = st_reset;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_reset;
        end else begin
            state <= state_next;
        end
    end

    // read held as a level for the whole fetch state
    assign read = (state == st_fetch);

    // instruction register and timer load together on accept
    assign ir_load     = accept;
    assign timer_start = accept;

    assign retire = finish; // one-cycle pulse

endmodule

/* src/mips_fetch_pkg.sv */
package mips_fetch_pkg;

    localparam logic [31:0] reset_vector = 32'hbfc00000; // boot rom entry

    // primary opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // funct field of special
    localparam logic [5:0] funct_jr    = 6'h08;
    localparam logic [5:0] funct_mult  = 6'h18;
    localparam logic [5:0] funct_multu = 6'h19;
    localparam logic [5:0] funct_div   = 6'h1a;
    localparam logic [5:0] funct_divu  = 6'h1b;

    typedef enum logic [1:0] {
        class_alu  = 2'd0,
        class_mem  = 2'd1,
        class_long = 2'd2
    } instr_class_t;

    // execute cycles per timing class
    localparam logic [2:0] exec_len_alu  = 3'd2;
    localparam logic [2:0] exec_len_mem  = 3'd3;
    localparam logic [2:0] exec_len_long = 3'd4;

    typedef enum logic [1:0] {
        st_reset = 2'd0,
        st_fetch = 2'd1,
        st_exec  = 2'd2
    } cycle_state_t;

    typedef enum logic [2:0] {
        xfer_none = 3'd0,
        xfer_beq  = 3'd1,
        xfer_bne  = 3'd2,
        xfer_j    = 3'd3, // jal too
        xfer_jr   = 3'd4
    } xfer_kind_t;

    typedef struct packed {
        logic        advance; // instruction retires
        logic        taken;   // redirect after delay slot
        logic [31:0] seq_pc;
        logic [31:0] target;
    } pc_update_t;

    typedef struct packed {
        logic        read;
        logic [31:0] address;
    } fetch_req_t;

endpackage
